//--- logic/mem_pkg.sv
//----------------------------------------
// Memory datapath definitions for the throughput tester
// Word width, memory and FIFO sizes, burst and block lengths
//----------------------------------------
`default_nettype none

package mem_pkg;

	localparam int WORD_W     = 32;
	localparam int MEM_DEPTH  = 256;
	localparam int MEM_ADDR_W = 8;
	localparam int BURST_LEN  = 16;   // Words per memory burst
	localparam int FIFO_DEPTH = 128;
	localparam int FIFO_CNT_W = 8;    // Holds 0 to FIFO_DEPTH
	localparam int BLOCK_SIZE = 64;   // Words per host block
	localparam int COUNT_W    = 27;

	typedef logic [WORD_W-1:0] word_t;

	// One request per cycle, a read when we is low
	typedef struct packed {
		logic                  we;
		logic [MEM_ADDR_W-1:0] addr;
		word_t                 wdata;
	} mem_req_t;

endpackage

`default_nettype wire

//--- logic/host_pkg.sv
//----------------------------------------
// Host side definitions: APB register map,
// control and status words, APB request bundle
//----------------------------------------
`default_nettype none

package host_pkg;
	import mem_pkg::*;

	localparam int APB_ADDR_W = 8;

	//----------------------------------------
	// Register map
	//----------------------------------------
	localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_INTERVAL = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_COUNT    = 8'h08;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] REG_DATA     = 8'h10;

	// reads_en lands in bit 0
	typedef struct packed {
		logic soft_rst;
		logic writes_en;
		logic reads_en;
	} ctrl_t;

	typedef struct packed {
		logic fifo_full;
		logic fifo_empty;
		logic block_ready;
		logic busy;
		logic writing;   // Bit 0
	} status_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		word_t                 pwdata;
	} apb_req_t;

endpackage

`default_nettype wire

//--- logic/block_mem.sv
//----------------------------------------
// Single-port block memory, write or read each cycle
// Read data valid one cycle after the request
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module block_mem
	import mem_pkg::*;
(
	input  wire           okClk,
	input  wire mem_req_t mem_req,
	output word_t         rdata
);

	word_t mem [MEM_DEPTH];

	always_ff @(posedge okClk) begin
		if (mem_req.we)
			mem[mem_req.addr] <= mem_req.wdata;
		rdata <= mem[mem_req.addr];   // Old data on a write
	end

endmodule

`default_nettype wire

//--- logic/out_fifo.sv
//----------------------------------------
// Output FIFO drained by the host over REG_DATA
// Raises block_ready while a full block is waiting
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module out_fifo
	import mem_pkg::*;
(
	input  wire                   okClk,
	input  wire                   rst_n,
	input  wire                   clr,
	input  wire                   push,
	input  wire word_t            wdata,
	input  wire                   pop,
	output word_t                 rdata,
	output logic                  empty,
	output logic                  full,
	output logic [FIFO_CNT_W-1:0] free,
	output logic                  block_ready
);

	word_t                          buffer [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr;
	logic [FIFO_CNT_W-1:0]          count;

	assign rdata = buffer[rd_ptr];   // Head shown without a read cycle
	assign empty = (count == '0);
	assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign free  = FIFO_CNT_W'(FIFO_DEPTH) - count;

	always_ff @(posedge okClk) begin
		if (push)
			buffer[wr_ptr] <= wdata;
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n || clr) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			block_ready <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// Block throttle
			block_ready <= (count >= FIFO_CNT_W'(BLOCK_SIZE));
		end
	end

	a_no_overflow: assert property (@(posedge okClk) disable iff (!rst_n)
		push |-> !full);

endmodule

`default_nettype wire

//--- logic/word_source.sv
//----------------------------------------
// Mock data source, one incrementing word per interval
// Word is held until the burst controller takes it
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module word_source
	import mem_pkg::*;
(
	input  wire        okClk,
	input  wire        rst_n,
	input  wire        clr,
	input  wire word_t interval,
	input  wire        src_take,
	output logic       src_valid,
	output word_t      src_word
);

	word_t tmr;

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			tmr       <= '0;
			src_valid <= 1'b0;
			src_word  <= '0;
		end else if (clr) begin
			tmr       <= '0;
			src_valid <= 1'b0;
			src_word  <= '0;
		end else if (src_valid) begin
			if (src_take) begin
				src_valid <= 1'b0;
				src_word  <= src_word + 1'b1;
			end
		end else if (tmr >= interval) begin   // Also copes with a lowered interval
			tmr       <= '0;
			src_valid <= 1'b1;
		end else begin
			tmr <= tmr + 1'b1;
		end
	end

	a_take_valid: assert property (@(posedge okClk) disable iff (!rst_n)
		src_take |-> src_valid);

endmodule

`default_nettype wire

//--- logic/burst_ctrl.sv
//----------------------------------------
// Burst engine between source, block memory and output FIFO
// Alternates write and read bursts of BURST_LEN words
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module burst_ctrl
	import mem_pkg::*;
	import host_pkg::*;
(
	input  wire                  okClk,
	input  wire                  rst_n,
	input  wire ctrl_t           ctrl,
	input  wire                  src_valid,
	input  wire word_t           src_word,
	output logic                 src_take,
	output mem_req_t             mem_req,
	input  wire word_t           mem_rdata,
	input  wire [FIFO_CNT_W-1:0] fifo_free,
	output logic                 fifo_push,
	output word_t                fifo_wdata,
	output logic [COUNT_W-1:0]   mem_count,
	output logic                 busy,
	output logic                 writing
);

	typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ} state_t;

	state_t                       state;
	logic [$clog2(BURST_LEN)-1:0] beat;
	logic [MEM_ADDR_W-1:0]        wr_ptr;
	logic [MEM_ADDR_W-1:0]        rd_ptr;
	logic [MEM_ADDR_W:0]          unread;    // Written but not yet read back
	logic                         last_wr;
	logic                         rd_pipe;   // Read data arrives this cycle
	logic                         can_wr;
	logic                         can_rd;
	logic                         last_beat;

	assign last_beat = (beat == ($clog2(BURST_LEN))'(BURST_LEN - 1));
	assign can_wr = ctrl.writes_en && (unread <= (MEM_ADDR_W+1)'(MEM_DEPTH - BURST_LEN));
	// Wait for the last push of a previous read burst so free is exact
	assign can_rd = ctrl.reads_en && !rd_pipe && (unread >= (MEM_ADDR_W+1)'(BURST_LEN))
		&& (fifo_free >= FIFO_CNT_W'(BURST_LEN));

	assign src_take   = (state == S_WRITE) && src_valid;
	assign fifo_push  = rd_pipe;
	assign fifo_wdata = mem_rdata;
	assign busy       = (state != S_IDLE);
	assign writing    = (state == S_WRITE);

	always_comb begin
		mem_req.we    = src_take;
		mem_req.addr  = (state == S_READ) ? rd_ptr : wr_ptr;
		mem_req.wdata = src_word;
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n || ctrl.soft_rst) begin
			state     <= S_IDLE;
			beat      <= '0;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			unread    <= '0;
			mem_count <= '0;
			last_wr   <= 1'b0;
			rd_pipe   <= 1'b0;
		end else begin
			rd_pipe <= (state == S_READ);
			case (state)
				S_IDLE: begin
					if (can_wr && (!can_rd || !last_wr)) begin
						state   <= S_WRITE;
						last_wr <= 1'b1;
					end else if (can_rd) begin
						state   <= S_READ;
						last_wr <= 1'b0;
					end
				end
				S_WRITE: if (src_take) begin
					wr_ptr <= wr_ptr + 1'b1;
					unread <= unread + 1'b1;
					beat   <= beat + 1'b1;
					if (last_beat) begin
						state     <= S_IDLE;
						mem_count <= mem_count + COUNT_W'(BURST_LEN);
					end
				end
				S_READ: begin   // One read per cycle
					rd_ptr <= rd_ptr + 1'b1;
					unread <= unread - 1'b1;
					beat   <= beat + 1'b1;
					if (last_beat)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_unread_max: assert property (@(posedge okClk) disable iff (!rst_n)
		unread <= (MEM_ADDR_W+1)'(MEM_DEPTH));

endmodule

`default_nettype wire

//--- logic/host_regs.sv
//----------------------------------------
// APB register block, zero wait states
// Holds CTRL and INTERVAL, pops the FIFO on DATA reads
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module host_regs
	import mem_pkg::*;
	import host_pkg::*;
(
	input  wire                okClk,
	input  wire                rst_n,
	input  wire apb_req_t      apb,
	output word_t              prdata,
	output logic               pready,
	output logic               pslverr,
	output ctrl_t              ctrl,
	output word_t              interval,
	input  wire [COUNT_W-1:0]  mem_count,
	input  wire word_t         fifo_rdata,
	input  wire                fifo_empty,
	input  wire                fifo_full,
	input  wire                block_ready,
	input  wire                busy,
	input  wire                writing,
	output logic               fifo_pop
);

	logic    access;
	logic    addr_ok;
	logic    data_rd;
	logic    wr_en;
	status_t status_w;

	assign access   = apb.psel & apb.penable;
	assign data_rd  = access & ~apb.pwrite & (apb.paddr == REG_DATA);
	assign wr_en    = access & apb.pwrite & addr_ok;
	assign pready   = 1'b1;   // No wait states
	assign pslverr  = access & (~addr_ok | (data_rd & fifo_empty));
	assign fifo_pop = data_rd & ~fifo_empty;

	assign status_w = '{fifo_full: fifo_full, fifo_empty: fifo_empty,
		block_ready: block_ready, busy: busy, writing: writing};

	always_comb begin
		prdata  = '0;
		addr_ok = 1'b1;
		case (apb.paddr)
			REG_CTRL:     prdata[$bits(ctrl_t)-1:0] = ctrl;
			REG_INTERVAL: prdata = interval;
			REG_COUNT:    prdata[COUNT_W-1:0] = mem_count;
			REG_STATUS:   prdata[$bits(status_t)-1:0] = status_w;
			REG_DATA:     prdata = fifo_rdata;   // FIFO head
			default:      addr_ok = 1'b0;
		endcase
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl     <= '0;
			interval <= '0;
		end else begin
			ctrl.soft_rst <= 1'b0;   // Single cycle pulse
			if (wr_en && apb.paddr == REG_CTRL)
				ctrl <= ctrl_t'(apb.pwdata[$bits(ctrl_t)-1:0]);
			if (wr_en && apb.paddr == REG_INTERVAL)
				interval <= apb.pwdata;
		end
	end

endmodule

`default_nettype wire

//--- logic/ramtest_top.sv
//----------------------------------------
// Memory throughput tester top level
// APB in, status and block-ready flag out
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ramtest_top
	import mem_pkg::*;
	import host_pkg::*;
(
	input  wire           okClk,
	input  wire           rst_n,
	input  wire apb_req_t apb,
	output word_t         prdata,
	output logic          pready,
	output logic          pslverr,
	output logic          block_ready,
	output status_t       status
);

	ctrl_t                 ctrl;
	word_t                 interval;
	logic [COUNT_W-1:0]    mem_count;
	word_t                 fifo_rdata;
	logic                  fifo_empty;
	logic                  fifo_full;
	logic                  fifo_pop;
	logic [FIFO_CNT_W-1:0] fifo_free;
	logic                  fifo_push;
	word_t                 fifo_wdata;
	logic                  busy;
	logic                  writing;
	logic                  src_valid;
	logic                  src_take;
	word_t                 src_word;
	mem_req_t              mem_req;
	word_t                 mem_rdata;

	assign status = '{fifo_full: fifo_full, fifo_empty: fifo_empty,
		block_ready: block_ready, busy: busy, writing: writing};

	host_regs u_regs (
		.okClk(okClk), .rst_n(rst_n), .apb(apb), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .ctrl(ctrl), .interval(interval), .mem_count(mem_count),
		.fifo_rdata(fifo_rdata), .fifo_empty(fifo_empty), .fifo_full(fifo_full),
		.block_ready(block_ready), .busy(busy), .writing(writing), .fifo_pop(fifo_pop)
	);

	word_source u_src (
		.okClk(okClk), .rst_n(rst_n), .clr(ctrl.soft_rst), .interval(interval),
		.src_take(src_take), .src_valid(src_valid), .src_word(src_word)
	);

	burst_ctrl u_burst (
		.okClk(okClk), .rst_n(rst_n), .ctrl(ctrl), .src_valid(src_valid),
		.src_word(src_word), .src_take(src_take), .mem_req(mem_req), .mem_rdata(mem_rdata),
		.fifo_free(fifo_free), .fifo_push(fifo_push), .fifo_wdata(fifo_wdata),
		.mem_count(mem_count), .busy(busy), .writing(writing)
	);

	block_mem u_mem (.okClk(okClk), .mem_req(mem_req), .rdata(mem_rdata));

	out_fifo u_fifo (
		.okClk(okClk), .rst_n(rst_n), .clr(ctrl.soft_rst), .push(fifo_push),
		.wdata(fifo_wdata), .pop(fifo_pop), .rdata(fifo_rdata), .empty(fifo_empty),
		.full(fifo_full), .free(fifo_free), .block_ready(block_ready)
	);

endmodule

`default_nettype wire

//--- tb/ramtest_tb.sv
//----------------------------------------
// Testbench for the memory throughput tester
// Replays APB operations from tb/ramtest_patterns.hex
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ramtest_tb
	import mem_pkg::*;
	import host_pkg::*;
();

	localparam int PAT_LINES = 64;
	localparam int FIELDS    = 6;   // op addr wdata exp err cmp

	logic        okClk = 1'b0;
	logic        rst_n;
	apb_req_t    apb;
	word_t       prdata;
	logic        pready;
	logic        pslverr;
	logic        block_ready;
	status_t     status;
	status_t     status_seen;   // Status pins during the access phase

	logic [31:0] pat [PAT_LINES*FIELDS];
	int          cyc = 0;
	int          limit = 32'h7fffffff;
	int          errors = 0;
	word_t       next_word;

	ramtest_top DUT (
		.okClk(okClk), .rst_n(rst_n), .apb(apb), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .block_ready(block_ready), .status(status)
	);

	always #2 okClk = ~okClk;

	always @(posedge okClk) begin
		cyc <= cyc + 1;
		if (cyc > limit) begin
			$display("Timeout: pattern list not finished after %0d cycles", cyc);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	task automatic check(input string name, input word_t act, input word_t exp);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, act, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic string reg_name(input logic [APB_ADDR_W-1:0] addr);
		case (addr)
			REG_CTRL:     return "REG_CTRL";
			REG_INTERVAL: return "REG_INTERVAL";
			REG_COUNT:    return "REG_COUNT";
			REG_STATUS:   return "REG_STATUS";
			REG_DATA:     return "REG_DATA";
			default:      return "prdata";
		endcase
	endfunction

	//----------------------------------------
	// APB transfer, setup then access phase
	//----------------------------------------
	task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input word_t wdata, output word_t rdata, output logic err);
		@(posedge okClk);
		apb.psel    <= 1'b1;
		apb.penable <= 1'b0;
		apb.pwrite  <= wr;
		apb.paddr   <= addr;
		apb.pwdata  <= wdata;
		@(posedge okClk);
		apb.penable <= 1'b1;
		@(negedge okClk);   // Mid access phase
		check("pready", 32'(pready), 32'd1);
		rdata       = prdata;
		err         = pslverr;
		status_seen = status;
		@(posedge okClk);
		apb.psel    <= 1'b0;
		apb.penable <= 1'b0;
	endtask

	// Source words arrive in order 0, 1, 2 ...
	task automatic pop_word();
		word_t rd;
		logic  err;
		apb_xfer(1'b0, REG_DATA, '0, rd, err);
		check("pslverr", 32'(err), 32'd0);
		check("REG_DATA", rd, next_word);
		next_word = next_word + 1;
	endtask

	task automatic drain_fifo();
		word_t   rd;
		logic    err;
		status_t st;
		int      n;
		n = 0;
		apb_xfer(1'b0, REG_STATUS, '0, rd, err);
		st = status_t'(rd[$bits(status_t)-1:0]);
		while (!st.fifo_empty && n <= FIFO_DEPTH) begin
			pop_word();
			n++;
			apb_xfer(1'b0, REG_STATUS, '0, rd, err);
			st = status_t'(rd[$bits(status_t)-1:0]);
		end
		if (!st.fifo_empty)
			abort_run("FIFO did not run empty while draining");
	endtask

	initial begin
		word_t                 rd;
		logic                  err;
		int                    op;
		int                    line;
		int                    total;
		logic [APB_ADDR_W-1:0] addr;
		word_t                 wdata;
		word_t                 exp;
		logic                  exp_err;
		logic                  cmp;
		rst_n <= 1'b0;
		apb   <= '0;
		$readmemh("tb/ramtest_patterns.hex", pat);

		// Cycle budget from the pattern list
		total = 0;
		line  = 0;
		while (line < PAT_LINES && pat[line*FIELDS] !== 32'd0) begin
			case (pat[line*FIELDS])
				32'd1, 32'd2, 32'd7: total += 3;
				32'd3:               total += int'(pat[line*FIELDS+2]);
				32'd4:               total += 1;
				32'd5:               total += 3 * int'(pat[line*FIELDS+2]);
				32'd6:               total += 6 * FIFO_DEPTH + 6;
				default:             abort_run("Unknown operation code in pattern file");
			endcase
			line++;
		end
		if (line == PAT_LINES)
			abort_run("Pattern file has no end marker");
		limit = 2 * total + 500;

		repeat (3) @(posedge okClk);
		rst_n <= 1'b1;

		line = 0;
		while (pat[line*FIELDS] !== 32'd0) begin
			op      = int'(pat[line*FIELDS]);
			addr    = pat[line*FIELDS+1][APB_ADDR_W-1:0];
			wdata   = pat[line*FIELDS+2];
			exp     = pat[line*FIELDS+3];
			exp_err = pat[line*FIELDS+4][0];
			cmp     = pat[line*FIELDS+5][0];
			case (op)
				1: begin
					apb_xfer(1'b1, addr, wdata, rd, err);
					check("pslverr", 32'(err), 32'(exp_err));
				end
				2: begin
					apb_xfer(1'b0, addr, '0, rd, err);
					check("pslverr", 32'(err), 32'(exp_err));
					if (cmp)
						check(reg_name(addr), rd, exp);
					if (cmp && addr == REG_STATUS)
						check("status", 32'(status_seen), exp);
				end
				3: repeat (wdata) @(posedge okClk);
				4: begin
					@(negedge okClk);
					check("block_ready", 32'(block_ready), exp);
				end
				5: begin
					next_word = exp;
					repeat (wdata) pop_word();
				end
				6: drain_fifo();
				default: begin   // Count register rules
					apb_xfer(1'b0, addr, '0, rd, err);
					check("pslverr", 32'(err), 32'd0);
					check("REG_COUNT[3:0]", 32'(rd[3:0]), 32'd0);
					check("REG_COUNT >= min", 32'(rd >= exp), 32'd1);
				end
			endcase
			line++;
		end

		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/ramtest_patterns.hex
// op addr wdata exp err cmp; op 1 write, 2 read, 3 wait wdata cycles, 4 block_ready pin,
// 5 read wdata words from exp, 6 drain FIFO, 7 count multiple of 16 and at least exp, 0 end
2 0C 00000000 00000008 0 1
2 00 00000000 00000000 0 1
2 04 00000000 00000000 0 1
4 00 00000000 00000000 0 0
1 04 00000002 00000000 0 0
2 04 00000000 00000002 0 1
1 20 12345678 00000000 1 0
2 20 00000000 00000000 1 0
2 10 00000000 00000000 1 0
2 0C 00000000 00000008 0 1
1 00 00000003 00000000 0 0
2 00 00000000 00000003 0 1
3 00 00000258 00000000 0 0
4 00 00000000 00000001 0 0
1 00 00000000 00000000 0 0
3 00 00000096 00000000 0 0
5 10 00000040 00000000 0 0
7 08 00000000 00000040 0 0
6 10 00000000 00000000 0 0
2 0C 00000000 00000008 0 1
2 10 00000000 00000000 1 0
1 00 00000004 00000000 0 0
2 08 00000000 00000000 0 1
2 0C 00000000 00000008 0 1
2 00 00000000 00000000 0 1
1 00 00000003 00000000 0 0
3 00 0000012C 00000000 0 0
5 10 00000001 00000000 0 0
1 00 00000000 00000000 0 0
0 00 00000000 00000000 0 0

//--- filelist.f
logic/mem_pkg.sv
logic/host_pkg.sv
logic/block_mem.sv
logic/out_fifo.sv
logic/word_source.sv
logic/burst_ctrl.sv
logic/host_regs.sv
logic/ramtest_top.sv
tb/ramtest_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module ramtest_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vramtest_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation binary returned status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
